/* logic/frontend_pkg.sv */
package frontend_pkg;

    // Machine and fetch sizes
    localparam int SS        = 2;
    localparam int XLEN      = 32;
    localparam int LINE_W    = SS * XLEN;
    localparam int IQ_DEPTH  = 8;
    localparam int IQ_PTR_W  = $clog2(IQ_DEPTH);
    localparam int REG_IDX_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // RV32I major opcodes
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;

    // Instruction formats with the MSB first
    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                 imm_20;
        logic [9:0]           imm_10_1;
        logic                 imm_11;
        logic [7:0]           imm_19_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } j_fmt_t;

    // One instruction word seen in every format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

    typedef enum logic [3:0] {
        alu_reg, alu_imm, load, store, branch,
        lui, auipc, jal, jalr, illegal
    } op_class_e;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      raw;
        op_class_e            op_class;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [2:0]           funct3;
        logic                 funct7_b5;
        logic [XLEN-1:0]      imm;
    } decoded_inst_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [LINE_W-1:0] data;
    } fetch_line_t;

    // Wishbone classic read request from the master side
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [XLEN-1:0] adr;
    } wb_req_t;

endpackage : frontend_pkg

/* logic/fetch_unit.sv */
module fetch_unit
import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Queue has room for a whole line
    input  logic              can_accept,

    // Wishbone classic read port
    input  logic [LINE_W-1:0] wb_dat_r,
    input  logic              wb_ack,
    output wb_req_t           wb_req,

    output fetch_line_t       line
);

logic [XLEN-1:0] pc;
logic            busy;
logic            done;

// Request completes on the ack cycle
assign done = busy && wb_ack;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc   <= RESET_PC;
        busy <= 1'b0;
    end else if (done) begin
        pc   <= pc + XLEN'(4 * SS);
        busy <= 1'b0;
    end else if (!busy && can_accept) begin
        busy <= 1'b1;
    end
end

// cyc and stb stay up from request to ack and adr is the line base
always_comb begin
    wb_req.cyc = busy;
    wb_req.stb = busy;
    wb_req.adr = pc;
end

// Line is only valid in the ack cycle; the queue writes it then
always_comb begin
    line.valid = done;
    line.pc    = pc;
    line.data  = wb_dat_r;
end

// Bus cycle ends in the cycle after the ack
a_cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.cyc && wb_ack) |=> (!wb_req.cyc && !wb_req.stb))
    else $error("cyc or stb still high in the cycle after ack");

// Pending request keeps its address until the slave answers
a_adr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr)))
    else $error("request dropped or adr changed before ack");

endmodule : fetch_unit

/* logic/inst_decoder.sv */
module inst_decoder
import frontend_pkg::*;
(
    input  rv_inst_u        word,
    input  logic [XLEN-1:0] pc,
    output decoded_inst_t   decoded
);

op_class_e       cls;
logic [XLEN-1:0] imm;
logic            has_rd;
logic            has_rs1;
logic            has_rs2;
logic            has_funct;

// Opcode to class
always_comb begin
    case (word.r.opcode)
        OP:      cls = alu_reg;
        OP_IMM:  cls = alu_imm;
        LOAD:    cls = load;
        STORE:   cls = store;
        BRANCH:  cls = branch;
        LUI:     cls = lui;
        AUIPC:   cls = auipc;
        JAL:     cls = jal;
        JALR:    cls = jalr;
        default: cls = illegal;
    endcase
end

// Immediate from the format that matches the class
always_comb begin
    case (cls)
        alu_imm, load, jalr: begin
            imm = {{20{word.i.imm[11]}}, word.i.imm};
        end
        store: begin
            imm = {{20{word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
        end
        branch: begin
            imm = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                   word.b.imm_10_5, word.b.imm_4_1, 1'b0};
        end
        lui, auipc: begin
            imm = {word.u.imm_31_12, 12'b0};
        end
        jal: begin
            imm = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                   word.j.imm_11, word.j.imm_10_1, 1'b0};
        end
        // Register ops carry no immediate and illegal words none either
        default: begin
            imm = '0;
        end
    endcase
end

// Which fields the format actually carries
always_comb begin
    has_rd    = !(cls inside {store, branch, illegal});
    has_rs1   = !(cls inside {lui, auipc, jal, illegal});
    has_rs2   = cls inside {alu_reg, store, branch};
    has_funct = cls inside {alu_reg, alu_imm, load, store, branch, jalr};
end

always_comb begin
    decoded.pc        = pc;
    decoded.raw       = word;
    decoded.op_class  = cls;
    decoded.rd        = has_rd  ? word.r.rd  : '0;
    decoded.rs1       = has_rs1 ? word.r.rs1 : '0;
    decoded.rs2       = has_rs2 ? word.r.rs2 : '0;
    decoded.funct3    = has_funct ? word.r.funct3 : 3'b000;
    // Bit 30 selects sub/sra and srai
    decoded.funct7_b5 = has_funct ? word.r.funct7[5] : 1'b0;
    decoded.imm       = imm;
end

endmodule : inst_decoder

/* logic/inst_queue.sv */
module inst_queue
import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // Whole decoded line written in one cycle
    input  logic          push,
    input  decoded_inst_t push_entries [SS],
    output logic          can_accept,

    // In-order output with valid/ready
    output decoded_inst_t out_inst,
    output logic          out_valid,
    input  logic          out_ready
);

decoded_inst_t       mem [IQ_DEPTH];
logic [IQ_PTR_W-1:0] head;
logic [IQ_PTR_W-1:0] tail;
logic [IQ_PTR_W:0]   count;
logic [IQ_PTR_W:0]   free_slots;
logic [IQ_PTR_W:0]   push_amt;
logic                pop;

assign pop        = out_valid && out_ready;
assign push_amt   = push ? (IQ_PTR_W+1)'(SS) : '0;
assign free_slots = (IQ_PTR_W+1)'(IQ_DEPTH) - count;

// Room for one more full line
assign can_accept = free_slots >= (IQ_PTR_W+1)'(SS);

assign out_valid = count != '0;
assign out_inst  = mem[head];

// Entry storage
// Depth is a power of two, so pointers wrap on their own
always_ff @(posedge clk) begin
    if (push) begin
        for (int k = 0; k < SS; k++) begin
            mem[tail + IQ_PTR_W'(k)] <= push_entries[k];
        end
    end
end

// Pointers and occupancy
always_ff @(posedge clk) begin
    if (!rst_n) begin
        head  <= '0;
        tail  <= '0;
        count <= '0;
    end else begin
        if (push) begin
            tail <= tail + IQ_PTR_W'(SS);
        end
        if (pop) begin
            head <= head + 1'b1;
        end
        count <= count + push_amt - {{IQ_PTR_W{1'b0}}, pop};
    end
end

// Fetch only requests with room, and pops in flight only add room
a_push_fits: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> can_accept)
    else $error("line pushed with fewer than SS free slots");

endmodule : inst_queue

/* logic/frontend_top.sv */
module frontend_top
import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    output wb_req_t           wb_req,
    input  logic [LINE_W-1:0] wb_dat_r,
    input  logic              wb_ack,

    output decoded_inst_t     out_inst,
    output logic              out_valid,
    input  logic              out_ready
);

fetch_line_t   line;
logic          can_accept;
decoded_inst_t dec_entries [SS];

fetch_unit i_fetch_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .can_accept (can_accept),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_req     (wb_req),
    .line       (line)
);

// One decoder per word of the line with word k at base + 4k
for (genvar k = 0; k < SS; k++) begin : g_decode
    inst_decoder i_inst_decoder (
        .word    (line.data[k*XLEN +: XLEN]),
        .pc      (line.pc + XLEN'(4 * k)),
        .decoded (dec_entries[k])
    );
end

inst_queue i_inst_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (line.valid),
    .push_entries (dec_entries),
    .can_accept   (can_accept),
    .out_inst     (out_inst),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
);

endmodule : frontend_top

/* testbench/frontend_checker.sv */
module frontend_checker
import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  wb_req_t       wb_req,
    input  logic          wb_ack,
    input  decoded_inst_t out_inst,
    input  logic          out_valid,
    input  logic          out_ready,
    input  logic [31:0]   image [256],
    output int            n_checked,
    output int            value_errors,
    output int            protocol_errors
);

timeunit 1ns;
timeprecision 100ps;

int      checked    = 0;
int      val_errs   = 0;
int      prot_errs  = 0;
// Entries written into the queue and not yet handed out
int      held       = 0;
logic    reset_seen = 1'b0;
logic    prev_rst_n = 1'b0;
logic    prev_ack   = 1'b0;
wb_req_t prev_req   = '0;

assign n_checked       = checked;
assign value_errors    = val_errs;
assign protocol_errors = prot_errs;

// Expected decode from the RV32I encoding tables
function automatic decoded_inst_t ref_decode(input logic [31:0] w, input logic [XLEN-1:0] pc);
    decoded_inst_t d;
    d           = '0;
    d.pc        = pc;
    d.raw       = w;
    d.rd        = w[11:7];
    d.rs1       = w[19:15];
    d.rs2       = w[24:20];
    d.funct3    = w[14:12];
    d.funct7_b5 = w[30];
    case (w[6:0])
        OP:      d.op_class = alu_reg;
        OP_IMM:  d.op_class = alu_imm;
        LOAD:    d.op_class = load;
        STORE:   d.op_class = store;
        BRANCH:  d.op_class = branch;
        LUI:     d.op_class = lui;
        AUIPC:   d.op_class = auipc;
        JAL:     d.op_class = jal;
        JALR:    d.op_class = jalr;
        default: d.op_class = illegal;
    endcase
    case (d.op_class)
        alu_imm, load, jalr: begin
            d.rs2 = '0;
            d.imm = {{20{w[31]}}, w[31:20]};
        end
        store: begin
            d.rd  = '0;
            d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        branch: begin
            d.rd  = '0;
            d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        lui, auipc, jal: begin
            d.rs1       = '0;
            d.rs2       = '0;
            d.funct3    = '0;
            d.funct7_b5 = 1'b0;
            if (d.op_class == jal) begin
                d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end else begin
                d.imm = {w[31:12], 12'b0};
            end
        end
        illegal: begin
            d          = '0;
            d.pc       = pc;
            d.raw      = w;
            d.op_class = illegal;
        end
        // Register ops keep every field and carry no immediate
        default: d.imm = '0;
    endcase
    return d;
endfunction

task automatic report_mismatch(input string test, input logic [127:0] exp_val,
                               input logic [127:0] act_val);
    $display("** Error %s: expected %0h, actual %0h (t=%0t)", test, exp_val, act_val, $time);
    val_errs++;
endtask

task automatic report_failure(input string what);
    $display("Protocol failure at %0t: %s", $time, what);
    prot_errs++;
endtask

task automatic check_bus();
    if (prev_req.stb && !prev_ack) begin
        if (!wb_req.stb) begin
            report_failure("stb dropped before the slave acked");
        end else if (wb_req.adr !== prev_req.adr) begin
            report_mismatch("wishbone adr held", 128'(prev_req.adr), 128'(wb_req.adr));
        end
    end
    if (prev_req.cyc && prev_ack && wb_req.cyc) begin
        report_failure("cyc still high in the cycle after ack");
    end
    if (wb_req.stb && (wb_req.adr % (4 * SS)) != 0) begin
        report_failure($sformatf("request adr %0h is not line aligned", wb_req.adr));
    end
    // New request needs room for a whole line
    if (wb_req.cyc && !prev_req.cyc && held > IQ_DEPTH - SS) begin
        report_failure($sformatf("cyc raised with %0d entries still held", held));
    end
    if (held > IQ_DEPTH) begin
        report_failure($sformatf("%0d entries held, more than the queue depth", held));
    end
endtask

task automatic check_transfer();
    logic [XLEN-1:0] exp_pc;
    logic [31:0]     exp_raw;
    decoded_inst_t   exp;
    string           test;
    exp_pc  = RESET_PC + XLEN'(4 * checked);
    exp_raw = image[exp_pc[9:2]];
    exp     = ref_decode(exp_raw, exp_pc);
    test    = (exp.op_class == illegal) ? "illegal decode" : "field decode";
    if (out_inst.pc !== exp_pc) begin
        report_mismatch("order", 128'(exp_pc), 128'(out_inst.pc));
    end
    if (out_inst.raw !== exp_raw) begin
        report_mismatch("image word", 128'(exp_raw), 128'(out_inst.raw));
    end
    if (out_inst !== exp) begin
        report_mismatch(test, 128'(exp), 128'(out_inst));
    end
    checked++;
endtask

always @(posedge clk) begin
    // Idle bus and empty output during reset and one cycle after
    if (reset_seen && (!rst_n || !prev_rst_n)) begin
        if (wb_req.cyc || wb_req.stb || out_valid) begin
            report_failure("cyc, stb or out_valid high during or right after reset");
        end
    end
    if (rst_n) begin
        check_bus();
        if (out_valid && out_ready) begin
            check_transfer();
        end
    end
    if (!rst_n) begin
        held = 0;
    end else begin
        held = held + ((wb_req.cyc && wb_ack) ? SS : 0) - ((out_valid && out_ready) ? 1 : 0);
    end
    reset_seen = reset_seen || !rst_n;
    prev_rst_n = rst_n;
    prev_req   = wb_req;
    prev_ack   = wb_ack;
end

endmodule : frontend_checker

/* testbench/tb_frontend.sv */
module tb_frontend
import frontend_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam logic [31:0] SEED         = 32'h0864_6a99;
localparam int          MEM_WORDS    = 256;
localparam int          NUM_OUT      = 200;
localparam int          MAX_CYCLES   = 5000;
localparam int          STALL_CYCLES = 30;

logic              clk       = 1'b0;
logic              rst_n     = 1'b0;
wb_req_t           wb_req;
logic [LINE_W-1:0] wb_dat_r  = '0;
logic              wb_ack    = 1'b0;
decoded_inst_t     out_inst;
logic              out_valid;
logic              out_ready = 1'b0;

logic [31:0] image [MEM_WORDS];
logic        pending    = 1'b0;
int          wait_left  = 0;
int          stall_left = STALL_CYCLES;
logic        timed_out  = 1'b0;
int          n_checked;
int          value_errors;
int          protocol_errors;

always #2 clk = ~clk;

frontend_top i_frontend_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .out_inst  (out_inst),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

frontend_checker i_frontend_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_req          (wb_req),
    .wb_ack          (wb_ack),
    .out_inst        (out_inst),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .image           (image),
    .n_checked       (n_checked),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors)
);

function automatic logic [6:0] pick_opcode(input int unsigned n);
    case (n)
        0:       return OP;
        1:       return OP_IMM;
        2:       return LOAD;
        3:       return STORE;
        4:       return BRANCH;
        5:       return LUI;
        6:       return AUIPC;
        7:       return JAL;
        default: return JALR;
    endcase
endfunction

// Mostly valid opcodes with about one word in five fully random
task automatic fill_image();
    logic [31:0] w;
    for (int a = 0; a < MEM_WORDS; a++) begin
        w = $urandom();
        if ($urandom_range(9, 0) >= 2) begin
            w[6:0] = pick_opcode($urandom_range(8, 0));
        end
        image[a] = w;
    end
endtask

// Wishbone slave with 0 to 3 wait states and output back-pressure
always @(negedge clk) begin
    logic [7:0] idx;
    out_ready = ($urandom_range(99, 0) < 70);
    // One long stall halfway through so the queue fills and fetch has to wait
    if (n_checked >= NUM_OUT / 2 && stall_left > 0) begin
        out_ready = 1'b0;
        stall_left--;
    end
    if (!rst_n || wb_ack) begin
        wb_ack  = 1'b0;
        pending = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
        if (!pending) begin
            pending   = 1'b1;
            wait_left = $urandom_range(3, 0);
        end
        if (wait_left == 0) begin
            idx = wb_req.adr[9:2];
            for (int k = 0; k < SS; k++) begin
                wb_dat_r[k*XLEN +: XLEN] = image[idx + 8'(k)];
            end
            wb_ack = 1'b1;
        end else begin
            wait_left--;
        end
    end
end

initial begin
    int cycles;
    void'($urandom(SEED));
    fill_image();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n  = 1'b1;
    cycles = 0;
    while (n_checked < NUM_OUT && !timed_out) begin
        @(negedge clk);
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            timed_out = 1'b1;
        end
    end
    if (timed_out) begin
        $display("Timeout: waited %0d cycles for %0d outputs, only %0d arrived",
                 cycles, NUM_OUT, n_checked);
    end
    $display("Checked %0d entries: %0d value errors, %0d protocol errors",
             n_checked, value_errors, protocol_errors);
    if (!timed_out && value_errors == 0 && protocol_errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : tb_frontend

/* compile.f */
logic/frontend_pkg.sv
logic/fetch_unit.sv
logic/inst_decoder.sv
logic/inst_queue.sv
logic/frontend_top.sv
testbench/frontend_checker.sv
testbench/tb_frontend.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module tb_frontend -Mdir obj_dir -o sim_frontend

run: compile
	@out="$$(./obj_dir/sim_frontend)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
